//--- design/branch_pkg.sv
// Branch subsystem definitions
`default_nettype none

package branch_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes

    // Data and address width
    localparam int xlen = 32;

    // Direct-mapped target buffer, indexed by pc[5:2]
    localparam int btb_entries = 16;
    localparam int btb_index_w = 4;
    localparam int btb_tag_w = 26;

    // Return address stack
    localparam int ras_depth = 4;
    localparam int ras_ptr_w = 2;

    // RV32 major opcodes for control transfer
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal = 7'b1101111;
    localparam logic [6:0] opc_jalr = 7'b1100111;

    ////////////////////////////////////////////////////////////
    // Enums

    // Conditional ops reuse their fn3 code, jumps take the two unused codes
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        jal  = 3'b010,
        jalr = 3'b011,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_op_t;

    // 2-bit saturating counter, upper bit is the prediction
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } counter_t;

    ////////////////////////////////////////////////////////////
    // Structs

    // Issue payload, 128 bits
    typedef struct packed {
        logic [31:0]     instruction;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rs1;
        logic [xlen-1:0] rs2;
    } branch_issue_t;

    // Execute stage result, also the buffer update
    typedef struct packed {
        logic [xlen-1:0] pc_ex;
        logic [xlen-1:0] jump_pc;
        logic [xlen-1:0] njump_pc;
        logic            taken;
        logic            is_return;
    } branch_result_t;

    // Fetch lookup answer
    typedef struct packed {
        logic            hit;
        logic            taken;
        logic            is_return;
        logic [xlen-1:0] target;
    } btb_predict_t;

endpackage

`default_nettype wire

//--- design/return_stack.sv
// Return address stack
`timescale 1ns/1ps
`default_nettype none

module return_stack (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           push,
    input  logic                           pop,
    input  logic [branch_pkg::xlen-1:0]    push_addr,
    output logic [branch_pkg::xlen-1:0]    top
);

    logic [branch_pkg::xlen-1:0] stack_mem [branch_pkg::ras_depth];

    // Points at the next free slot
    logic [branch_pkg::ras_ptr_w-1:0] ptr;
    logic [branch_pkg::ras_ptr_w-1:0] top_ptr;

    assign top_ptr = ptr - 1'b1;
    assign top     = stack_mem[top_ptr];

    ////////////////////////////////////////////////////////////
    // Pointer

    // Wraps both ways, overflow drops the oldest entry
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (push) begin
            ptr <= ptr + 1'b1;
        end else if (pop) begin
            ptr <= top_ptr;
        end
    end

    ////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (push) begin
            stack_mem[ptr] <= push_addr;
        end
    end

endmodule

`default_nettype wire

//--- design/branch_target_buffer.sv
// Branch target buffer
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [branch_pkg::xlen-1:0]    fetch_pc,
    output branch_pkg::btb_predict_t       fetch_predict,
    input  logic                           resolve_valid,
    input  branch_pkg::branch_result_t     br_result,
    input  logic [branch_pkg::xlen-1:0]    ras_top
);

    localparam int idx_lo = 2;
    localparam int tag_lo = idx_lo + branch_pkg::btb_index_w;

    // Stored per entry, valid kept apart
    typedef struct packed {
        logic [branch_pkg::btb_tag_w-1:0] tag;
        branch_pkg::counter_t             ctr;
        logic                             is_return;
        logic [branch_pkg::xlen-1:0]      target;
    } btb_entry_t;

    logic [branch_pkg::btb_entries-1:0] valid_q;
    btb_entry_t entry_mem [branch_pkg::btb_entries];

    logic [branch_pkg::btb_index_w-1:0] rd_idx;
    logic [branch_pkg::btb_tag_w-1:0]   rd_tag;
    btb_entry_t                         rd_entry;
    logic                               rd_hit;

    logic [branch_pkg::btb_index_w-1:0] wr_idx;
    logic [branch_pkg::btb_tag_w-1:0]   wr_tag;
    btb_entry_t                         wr_entry;
    logic                               upd_hit;
    logic                               wr_en;

    // Step one state toward the outcome, stop at the ends
    function automatic branch_pkg::counter_t saturate(branch_pkg::counter_t c, logic taken);
        logic [1:0] v;
        v = c;
        if (taken && v != 2'b11) begin
            v = v + 2'd1;
        end else if (!taken && v != 2'b00) begin
            v = v - 2'd1;
        end
        return branch_pkg::counter_t'(v);
    endfunction

    ////////////////////////////////////////////////////////////
    // Lookup

    assign rd_idx   = fetch_pc[tag_lo-1:idx_lo];
    assign rd_tag   = fetch_pc[branch_pkg::xlen-1:tag_lo];
    assign rd_entry = entry_mem[rd_idx];
    assign rd_hit   = valid_q[rd_idx] && (rd_entry.tag == rd_tag);

    assign fetch_predict.hit       = rd_hit;
    assign fetch_predict.taken     = rd_hit & rd_entry.ctr[1];
    assign fetch_predict.is_return = rd_hit & rd_entry.is_return;
    // Returns take their target from the stack
    assign fetch_predict.target    = rd_entry.is_return ? ras_top : rd_entry.target;

    ////////////////////////////////////////////////////////////
    // Update

    assign wr_idx  = br_result.pc_ex[tag_lo-1:idx_lo];
    assign wr_tag  = br_result.pc_ex[branch_pkg::xlen-1:tag_lo];
    assign upd_hit = valid_q[wr_idx] && (entry_mem[wr_idx].tag == wr_tag);
    // Allocate on a miss only when taken
    assign wr_en   = resolve_valid && (upd_hit || br_result.taken);

    always_comb begin
        wr_entry.tag       = wr_tag;
        wr_entry.ctr       = upd_hit ? saturate(entry_mem[wr_idx].ctr, br_result.taken)
                                     : branch_pkg::weak_taken;
        wr_entry.is_return = br_result.is_return;
        wr_entry.target    = br_result.jump_pc;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            entry_mem[wr_idx] <= wr_entry;
        end
    end

endmodule

`default_nettype wire

//--- design/branch_unit.sv
// Branch resolution unit
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  logic                           clk,
    input  logic                           rst,
    input  branch_pkg::branch_issue_t      issue,
    input  logic                           issue_valid,
    output logic                           issue_ready,
    input  logic [branch_pkg::xlen-1:0]    dec_pc,
    input  logic                           dec_pc_valid,
    output branch_pkg::branch_result_t     br_result,
    output logic                           resolve_valid,
    output logic                           branch_flush,
    output logic [branch_pkg::xlen-1:0]    redirect_pc,
    output logic                           ras_push,
    output logic                           ras_pop,
    output logic [branch_pkg::xlen-1:0]    push_addr
);

    // Instruction fields
    logic [6:0] opcode;
    logic [2:0] fn3;
    logic [4:0] rd_idx;
    logic [4:0] rs1_idx;
    branch_pkg::branch_op_t op;

    // Immediates and target arithmetic
    logic [branch_pkg::xlen-1:0] imm_b;
    logic [branch_pkg::xlen-1:0] imm_j;
    logic [branch_pkg::xlen-1:0] imm_i;
    logic [branch_pkg::xlen-1:0] offset;
    logic [branch_pkg::xlen-1:0] base;
    logic [branch_pkg::xlen-1:0] target;

    // Condition
    logic rs_equal;
    logic rs_less_signed;
    logic rs_less_unsigned;
    logic cond_taken;

    // Link register convention
    logic rd_link;
    logic rs1_link;
    logic is_call;
    logic is_return;

    logic accept;
    logic pending;
    logic [branch_pkg::xlen-1:0] next_pc;

    ////////////////////////////////////////////////////////////
    // Decode

    assign opcode  = issue.instruction[6:0];
    assign fn3     = issue.instruction[14:12];
    assign rd_idx  = issue.instruction[11:7];
    assign rs1_idx = issue.instruction[19:15];

    always_comb begin
        case (opcode)
            branch_pkg::opc_jal:  op = branch_pkg::jal;
            branch_pkg::opc_jalr: op = branch_pkg::jalr;
            default:              op = branch_pkg::branch_op_t'(fn3);
        endcase
    end

    // B, J and I immediate forms, sign extended
    assign imm_b = {{19{issue.instruction[31]}}, issue.instruction[31], issue.instruction[7],
                    issue.instruction[30:25], issue.instruction[11:8], 1'b0};
    assign imm_j = {{11{issue.instruction[31]}}, issue.instruction[31],
                    issue.instruction[19:12], issue.instruction[20],
                    issue.instruction[30:21], 1'b0};
    assign imm_i = {{20{issue.instruction[31]}}, issue.instruction[31:20]};

    always_comb begin
        case (op)
            branch_pkg::jal:  offset = imm_j;
            branch_pkg::jalr: offset = imm_i;
            default:          offset = imm_b;
        endcase
    end

    // Only jalr is register relative
    assign base   = (op == branch_pkg::jalr) ? issue.rs1 : issue.pc;
    assign target = base + offset;

    ////////////////////////////////////////////////////////////
    // Condition evaluation

    assign rs_equal         = issue.rs1 == issue.rs2;
    assign rs_less_signed   = $signed(issue.rs1) < $signed(issue.rs2);
    assign rs_less_unsigned = issue.rs1 < issue.rs2;

    always_comb begin
        case (op)
            branch_pkg::beq:  cond_taken = rs_equal;
            branch_pkg::bne:  cond_taken = ~rs_equal;
            branch_pkg::blt:  cond_taken = rs_less_signed;
            branch_pkg::bge:  cond_taken = ~rs_less_signed;
            branch_pkg::bltu: cond_taken = rs_less_unsigned;
            branch_pkg::bgeu: cond_taken = ~rs_less_unsigned;
            default:          cond_taken = 1'b1;
        endcase
    end

    // x1 and x5 are the link registers
    assign rd_link  = (rd_idx == 5'd1) || (rd_idx == 5'd5);
    assign rs1_link = (rs1_idx == 5'd1) || (rs1_idx == 5'd5);
    assign is_call  = ((op == branch_pkg::jal) || (op == branch_pkg::jalr)) && rd_link;
    assign is_return = (op == branch_pkg::jalr) && rs1_link && !rd_link
                       && (issue.instruction[31:20] == 12'd0);

    ////////////////////////////////////////////////////////////
    // Execute registers

    assign issue_ready = ~pending;
    assign accept      = issue_valid & issue_ready;

    // Held until decode shows the following instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (resolve_valid) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            br_result.pc_ex     <= issue.pc;
            br_result.jump_pc   <= {target[branch_pkg::xlen-1:1], 1'b0};
            br_result.njump_pc  <= issue.pc + 32'd4;
            br_result.taken     <= cond_taken;
            br_result.is_return <= is_return;
        end
    end

    // One-cycle stack pulses after acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            ras_push <= 1'b0;
            ras_pop  <= 1'b0;
        end else begin
            ras_push <= accept & is_call;
            ras_pop  <= accept & is_return;
        end
    end

    // Return address is the fall-through
    assign push_addr = br_result.njump_pc;

    ////////////////////////////////////////////////////////////
    // Resolution against decode

    assign next_pc       = br_result.taken ? br_result.jump_pc : br_result.njump_pc;
    assign resolve_valid = pending & dec_pc_valid;
    assign branch_flush  = resolve_valid && (dec_pc != next_pc);
    assign redirect_pc   = next_pc;

endmodule

`default_nettype wire

//--- design/branch_top.sv
// Branch subsystem top level
`timescale 1ns/1ps
`default_nettype none

module branch_top (
    input  logic                           clk,
    input  logic                           rst,
    input  branch_pkg::branch_issue_t      issue,
    input  logic                           issue_valid,
    output logic                           issue_ready,
    input  logic [branch_pkg::xlen-1:0]    dec_pc,
    input  logic                           dec_pc_valid,
    output logic                           branch_flush,
    output logic [branch_pkg::xlen-1:0]    redirect_pc,
    output logic                           resolve_valid,
    output branch_pkg::branch_result_t     br_result,
    input  logic [branch_pkg::xlen-1:0]    fetch_pc,
    output branch_pkg::btb_predict_t       fetch_predict
);

    // Unit to stack
    logic                        ras_push;
    logic                        ras_pop;
    logic [branch_pkg::xlen-1:0] push_addr;

    // Stack to buffer
    logic [branch_pkg::xlen-1:0] ras_top;

    branch_unit u_branch_unit (
        .clk           (clk),
        .rst           (rst),
        .issue         (issue),
        .issue_valid   (issue_valid),
        .issue_ready   (issue_ready),
        .dec_pc        (dec_pc),
        .dec_pc_valid  (dec_pc_valid),
        .br_result     (br_result),
        .resolve_valid (resolve_valid),
        .branch_flush  (branch_flush),
        .redirect_pc   (redirect_pc),
        .ras_push      (ras_push),
        .ras_pop       (ras_pop),
        .push_addr     (push_addr)
    );

    // Learns from every resolved branch
    branch_target_buffer u_btb (
        .clk           (clk),
        .rst           (rst),
        .fetch_pc      (fetch_pc),
        .fetch_predict (fetch_predict),
        .resolve_valid (resolve_valid),
        .br_result     (br_result),
        .ras_top       (ras_top)
    );

    return_stack u_ras (
        .clk       (clk),
        .rst       (rst),
        .push      (ras_push),
        .pop       (ras_pop),
        .push_addr (push_addr),
        .top       (ras_top)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
// Testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // 10 ns period
    localparam realtime half_period = 5ns;

    initial begin
        clk = 1'b0;
        forever begin
            #(half_period) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- testbench/branch_asserts.sv
// Branch unit assertions
`timescale 1ns/1ps
`default_nettype none

module branch_asserts (
    input logic clk,
    input logic rst,
    input logic issue_valid,
    input logic issue_ready,
    input logic resolve_valid,
    input logic branch_flush,
    input logic ras_push,
    input logic ras_pop
);

    // Read by the testbench top
    int unsigned fail_count;

    initial fail_count = 0;

    // A flush only comes out of a resolution
    flush_needs_resolve: assert property (@(posedge clk) disable iff (rst)
        branch_flush |-> resolve_valid)
        else begin
            $error("branch_flush without resolve_valid");
            fail_count++;
        end

    push_pop_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(ras_push && ras_pop))
        else begin
            $error("ras_push and ras_pop high together");
            fail_count++;
        end

    // Second branch held back
    ready_drops_after_accept: assert property (@(posedge clk) disable iff (rst)
        (issue_valid && issue_ready) |=> !issue_ready)
        else begin
            $error("issue_ready high after acceptance");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- testbench/branch_tb.sv
// Branch subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module branch_tb;

    // Branch counts per phase, used for the timeout
    localparam int n_cond = 60;
    localparam int n_jump = 20;
    localparam int n_good = 30;
    localparam int n_learn = 13;
    localparam int n_calls = 5;
    localparam int n_branches = n_cond + n_jump + n_good + n_learn + 2 * n_calls;
    localparam int test_cycles = 8 + n_branches * 9;
    localparam int cycle_limit = test_cycles * 4;

    logic clk;
    logic rst;
    branch_pkg::branch_issue_t  issue;
    logic                       issue_valid;
    logic                       issue_ready;
    logic [31:0]                dec_pc;
    logic                       dec_pc_valid;
    logic                       branch_flush;
    logic [31:0]                redirect_pc;
    logic                       resolve_valid;
    branch_pkg::branch_result_t br_result;
    logic [31:0]                fetch_pc;
    branch_pkg::btb_predict_t   fetch_predict;

    int          cycle_count;
    logic [31:0] lfsr_state;

    // Buffer and stack model
    logic                         m_valid [branch_pkg::btb_entries];
    logic [branch_pkg::btb_tag_w-1:0] m_tag [branch_pkg::btb_entries];
    branch_pkg::counter_t         m_ctr [branch_pkg::btb_entries];
    logic                         m_ret [branch_pkg::btb_entries];
    logic [31:0]                  m_target [branch_pkg::btb_entries];
    logic [31:0]                  m_stack [branch_pkg::ras_depth];
    logic [branch_pkg::ras_ptr_w-1:0] m_ptr;

    tb_clock u_tb_clock (
        .clk (clk)
    );

    branch_top u_branch_top (
        .clk           (clk),
        .rst           (rst),
        .issue         (issue),
        .issue_valid   (issue_valid),
        .issue_ready   (issue_ready),
        .dec_pc        (dec_pc),
        .dec_pc_valid  (dec_pc_valid),
        .branch_flush  (branch_flush),
        .redirect_pc   (redirect_pc),
        .resolve_valid (resolve_valid),
        .br_result     (br_result),
        .fetch_pc      (fetch_pc),
        .fetch_predict (fetch_predict)
    );

    bind branch_unit branch_asserts u_branch_asserts (
        .clk           (clk),
        .rst           (rst),
        .issue_valid   (issue_valid),
        .issue_ready   (issue_ready),
        .resolve_valid (resolve_valid),
        .branch_flush  (branch_flush),
        .ras_push      (ras_push),
        .ras_pop       (ras_pop)
    );

    ////////////////////////////////////////////////////////////
    // Failure handling and compare tasks

    task automatic halt_with_failure();
        $display("tests failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_flush(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Fail time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
            halt_with_failure();
        end
    endtask

    task automatic check_addr(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
            halt_with_failure();
        end
    endtask

    task automatic check_result(input string name, input branch_pkg::branch_result_t exp,
                                input branch_pkg::branch_result_t act);
        if (exp !== act) begin
            $display("Fail time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
            halt_with_failure();
        end
    endtask

    // Target is don't care on a miss
    task automatic check_predict(input string name, input branch_pkg::btb_predict_t exp,
                                 input branch_pkg::btb_predict_t act);
        logic bad;
        bad = exp.hit ? (exp !== act)
                      : ({exp.hit, exp.taken, exp.is_return}
                         !== {act.hit, act.taken, act.is_return});
        if (bad) begin
            $display("Fail time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
            halt_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Random source

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model

    function automatic logic link_reg(input logic [4:0] r);
        return (r == 5'd1) || (r == 5'd5);
    endfunction

    function automatic logic is_call_instr(input logic [31:0] ins);
        return ((ins[6:0] == branch_pkg::opc_jal) || (ins[6:0] == branch_pkg::opc_jalr))
               && link_reg(ins[11:7]);
    endfunction

    // RV32 branch semantics straight from the ISA rules
    function automatic branch_pkg::branch_result_t ref_branch(
        input branch_pkg::branch_issue_t b);
        branch_pkg::branch_result_t r;
        logic [31:0] ins;
        logic [31:0] imm;
        logic [31:0] sum;
        logic        taken;
        ins = b.instruction;
        taken = 1'b1;
        if (ins[6:0] == branch_pkg::opc_jal) begin
            imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            sum = b.pc + imm;
        end else if (ins[6:0] == branch_pkg::opc_jalr) begin
            imm = {{20{ins[31]}}, ins[31:20]};
            sum = b.rs1 + imm;
        end else begin
            imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            sum = b.pc + imm;
            case (ins[14:12])
                3'b000:  taken = b.rs1 == b.rs2;
                3'b001:  taken = b.rs1 != b.rs2;
                3'b100:  taken = $signed(b.rs1) < $signed(b.rs2);
                3'b101:  taken = $signed(b.rs1) >= $signed(b.rs2);
                3'b110:  taken = b.rs1 < b.rs2;
                default: taken = b.rs1 >= b.rs2;
            endcase
        end
        r.pc_ex = b.pc;
        r.jump_pc = sum & ~32'd1;
        r.njump_pc = b.pc + 32'd4;
        r.taken = taken;
        r.is_return = (ins[6:0] == branch_pkg::opc_jalr) && link_reg(ins[19:15])
                      && !link_reg(ins[11:7]) && (imm == 32'd0);
        return r;
    endfunction

    function automatic branch_pkg::counter_t step_counter(input branch_pkg::counter_t c,
                                                          input logic t);
        case (c)
            branch_pkg::strong_not_taken:
                return t ? branch_pkg::weak_not_taken : branch_pkg::strong_not_taken;
            branch_pkg::weak_not_taken:
                return t ? branch_pkg::weak_taken : branch_pkg::strong_not_taken;
            branch_pkg::weak_taken:
                return t ? branch_pkg::strong_taken : branch_pkg::weak_not_taken;
            default:
                return t ? branch_pkg::strong_taken : branch_pkg::weak_taken;
        endcase
    endfunction

    function automatic branch_pkg::btb_predict_t model_predict(input logic [31:0] pc);
        branch_pkg::btb_predict_t p;
        logic [3:0] idx;
        logic [branch_pkg::ras_ptr_w-1:0] tp;
        idx = pc[5:2];
        tp = m_ptr - 2'd1;
        p.hit = m_valid[idx] && (m_tag[idx] == pc[31:6]);
        p.taken = p.hit && ((m_ctr[idx] == branch_pkg::weak_taken)
                            || (m_ctr[idx] == branch_pkg::strong_taken));
        p.is_return = p.hit && m_ret[idx];
        p.target = m_ret[idx] ? m_stack[tp] : m_target[idx];
        return p;
    endfunction

    task automatic model_update(input branch_pkg::branch_result_t r, input logic call);
        logic [3:0] idx;
        logic       hit;
        idx = r.pc_ex[5:2];
        hit = m_valid[idx] && (m_tag[idx] == r.pc_ex[31:6]);
        if (hit) begin
            m_ctr[idx] = step_counter(m_ctr[idx], r.taken);
        end else if (r.taken) begin
            m_valid[idx] = 1'b1;
            m_tag[idx] = r.pc_ex[31:6];
            m_ctr[idx] = branch_pkg::weak_taken;
        end
        if (hit || r.taken) begin
            m_target[idx] = r.jump_pc;
            m_ret[idx] = r.is_return;
        end
        // Circular stack, the oldest slot is overwritten
        if (call) begin
            m_stack[m_ptr] = r.njump_pc;
            m_ptr = m_ptr + 2'd1;
        end else if (r.is_return) begin
            m_ptr = m_ptr - 2'd1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus

    // Issue, resolve against decode, then check the lookup
    task automatic run_branch(input branch_pkg::branch_issue_t b, input logic use_correct,
                              input int idle);
        branch_pkg::branch_result_t exp;
        logic [31:0] next;
        logic [31:0] dpc;
        exp = ref_branch(b);
        next = exp.taken ? exp.jump_pc : exp.njump_pc;
        dpc = use_correct ? next : b.pc + 32'd4;
        @(negedge clk);
        while (!issue_ready) @(negedge clk);
        @(posedge clk);
        issue <= b;
        issue_valid <= 1'b1;
        @(posedge clk);
        issue_valid <= 1'b0;
        // Decode stalls
        repeat (idle) @(posedge clk);
        dec_pc <= dpc;
        dec_pc_valid <= 1'b1;
        fetch_pc <= b.pc;
        @(negedge clk);
        while (!resolve_valid) @(negedge clk);
        check_flush("branch_flush", dpc != next, branch_flush);
        check_addr("redirect_pc", next, redirect_pc);
        check_result("br_result", exp, br_result);
        @(posedge clk);
        dec_pc_valid <= 1'b0;
        model_update(exp, is_call_instr(b.instruction));
        @(negedge clk);
        check_predict("fetch_predict", model_predict(b.pc), fetch_predict);
    endtask

    task automatic make_cond(output branch_pkg::branch_issue_t b);
        logic [31:0] v;
        rand_bits(32, b.instruction);
        rand_bits(3, v);
        // Codes 010 and 011 are not branches, fold them onto blt and bge
        if (v[2:1] == 2'b01) begin
            v[2:0] = v[2:0] ^ 3'b110;
        end
        b.instruction[14:12] = v[2:0];
        b.instruction[6:0] = branch_pkg::opc_branch;
        rand_bits(32, b.pc);
        b.pc[1:0] = 2'b00;
        rand_bits(32, b.rs1);
        rand_bits(1, v);
        if (v[0]) begin
            b.rs2 = b.rs1;
        end else begin
            rand_bits(32, b.rs2);
        end
    endtask

    task automatic make_jump(output branch_pkg::branch_issue_t b);
        logic [31:0] v;
        rand_bits(32, b.instruction);
        rand_bits(1, v);
        b.instruction[6:0] = v[0] ? branch_pkg::opc_jalr : branch_pkg::opc_jal;
        rand_bits(32, b.pc);
        b.pc[1:0] = 2'b00;
        rand_bits(32, b.rs1);
        b.rs1[0] = 1'b1;
        rand_bits(32, b.rs2);
    endtask

    // beq at a fixed pc with a chosen outcome
    task automatic learn_branch(input logic [31:0] pc, input logic taken);
        branch_pkg::branch_issue_t b;
        rand_bits(32, b.instruction);
        b.instruction[14:12] = 3'b000;
        b.instruction[6:0] = branch_pkg::opc_branch;
        b.pc = pc;
        rand_bits(32, b.rs1);
        b.rs2 = taken ? b.rs1 : ~b.rs1;
        run_branch(b, 1'b1, 0);
    endtask

    ////////////////////////////////////////////////////////////
    // Timeout and assertion watch

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: test did not finish within %0d cycles", cycle_limit);
            halt_with_failure();
        end
    end

    always @(negedge clk) begin
        if (u_branch_top.u_branch_unit.u_branch_asserts.fail_count != 0) begin
            $display("Assertion on the branch unit failed at time %0t", $time);
            halt_with_failure();
        end
    end

    initial begin
        branch_pkg::branch_issue_t b;
        logic [31:0] v;
        logic [branch_pkg::ras_ptr_w-1:0] tp;
        rst = 1'b1;
        issue = '0;
        issue_valid = 1'b0;
        dec_pc = '0;
        dec_pc_valid = 1'b0;
        fetch_pc = '0;
        cycle_count = 0;
        lfsr_state = 32'd19;
        m_ptr = '0;
        for (int i = 0; i < branch_pkg::btb_entries; i++) begin
            m_valid[i] = 1'b0;
            m_tag[i] = '0;
            m_ctr[i] = branch_pkg::strong_not_taken;
            m_ret[i] = 1'b0;
            m_target[i] = '0;
        end
        for (int i = 0; i < branch_pkg::ras_depth; i++) begin
            m_stack[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Reset state
        @(negedge clk);
        check_flush("issue_ready", 1'b1, issue_ready);
        check_flush("branch_flush", 1'b0, branch_flush);
        check_flush("resolve_valid", 1'b0, resolve_valid);
        check_predict("fetch_predict", model_predict(fetch_pc), fetch_predict);

        // Conditional branches, decode falls through
        for (int i = 0; i < n_cond; i++) begin
            make_cond(b);
            run_branch(b, 1'b0, 0);
        end

        // Jumps, decode falls through
        for (int i = 0; i < n_jump; i++) begin
            make_jump(b);
            run_branch(b, 1'b0, 0);
        end

        // Front end on the right path, with decode stalls
        for (int i = 0; i < n_good; i++) begin
            rand_bits(1, v);
            if (v[0]) begin
                make_jump(b);
            end else begin
                make_cond(b);
            end
            rand_bits(2, v);
            run_branch(b, 1'b1, int'(v[1:0]));
        end

        // Counter training, 0x2040 shares index 0 with 0x1040
        repeat (3) learn_branch(32'h0000_1040, 1'b1);
        repeat (4) learn_branch(32'h0000_1040, 1'b0);
        learn_branch(32'h0000_1008, 1'b0);
        learn_branch(32'h0000_1008, 1'b1);
        learn_branch(32'h0000_2040, 1'b1);
        learn_branch(32'h0000_1040, 1'b0);
        learn_branch(32'h0000_1040, 1'b1);
        learn_branch(32'h0000_2040, 1'b1);

        // Nested calls through x1, one more than the stack holds
        for (int i = 0; i < n_calls; i++) begin
            rand_bits(32, b.instruction);
            b.instruction[11:7] = 5'd1;
            b.instruction[6:0] = branch_pkg::opc_jal;
            b.pc = 32'h0000_3000 + 32'h100 * i;
            rand_bits(32, b.rs1);
            rand_bits(32, b.rs2);
            run_branch(b, 1'b1, 0);
        end

        // jalr x0, 0(x1) back to the model's top
        for (int i = 0; i < n_calls; i++) begin
            tp = m_ptr - 2'd1;
            b.instruction = 32'h0000_8067;
            b.pc = 32'h0000_5000 + 32'd4 * i;
            b.rs1 = m_stack[tp];
            b.rs2 = '0;
            run_branch(b, 1'b1, 0);
        end

        repeat (2) @(negedge clk);
        if (u_branch_top.u_branch_unit.u_branch_asserts.fail_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            halt_with_failure();
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
design/branch_pkg.sv
design/return_stack.sv
design/branch_target_buffer.sv
design/branch_unit.sv
design/branch_top.sv
testbench/tb_clock.sv
testbench/branch_asserts.sv
testbench/branch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run the branch subsystem testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module branch_tb -f filelist.f -o branch_sim && \
    ./obj_dir/branch_sim +verilator+error+limit+100 \
        | tee /dev/stderr | grep -q "^all tests passed$" && \
    echo "simulation result: PASS" || \
    { echo "simulation result: FAIL"; exit 1; }
